// ==== lsu_addr_gen.sv ====
`timescale 1ns/1ns

module lsu_addr_gen import lsu_pkg::*; (
    input  logic [XLEN-1:0]           base_i,
    input  logic [XLEN-1:0]           imm_i,
    input  mem_size_e                 size_i,
    output logic [XLEN-1:0]           vaddr_o,
    output logic [BYTES_PER_WORD-1:0] mask_o,
    output logic                      misalign_o
);

    logic [OFFSET_W-1:0] offset;

    assign vaddr_o = base_i + imm_i;
    assign offset  = vaddr_o[OFFSET_W-1:0];

    // lanes touched by the access
    always_comb begin
        case (size_i)
            SIZE_BYTE: mask_o = BYTES_PER_WORD'(1) << offset;
            SIZE_HALF: mask_o = BYTES_PER_WORD'(3) << offset;
            default:   mask_o = '1;
        endcase
    end

    always_comb begin
        case (size_i)
            SIZE_HALF: misalign_o = offset[0];
            SIZE_WORD: misalign_o = |offset;
            default:   misalign_o = 1'b0;
        endcase
    end

endmodule

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ns

module lsu_ctrl import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_i,
    input  mem_op_e                   op_i,
    input  mem_size_e                 size_i,
    input  logic                      uext_i,
    input  logic [XLEN-1:0]           base_i,
    input  logic [XLEN-1:0]           imm_i,
    input  logic [XLEN-1:0]           wdata_i,
    input  logic                      sb_full_i,
    input  logic [BYTES_PER_WORD-1:0] fwd_mask_i,
    input  logic [XLEN-1:0]           fwd_data_i,
    input  logic [XLEN-1:0]           ram_data_i,
    output logic                      ack_o,
    output logic [XLEN-1:0]           rdata_o,
    output exc_code_e                 exc_o,
    output logic                      ram_rd_en_o,
    output logic [MEM_IDX_W-1:0]      ram_rd_idx_o,
    output logic                      sb_push_o,
    output logic [XLEN-1:0]           sb_addr_o,
    output logic [BYTES_PER_WORD-1:0] sb_mask_o,
    output logic [XLEN-1:0]           sb_data_o,
    output logic [XLEN-1:0]           fwd_addr_o,
    output logic                      exc_set_o,
    output exc_code_e                 exc_code_o,
    output logic [XLEN-1:0]           exc_vaddr_o
);

    lsu_state_e state_q, state_d;

    mem_op_e                   op_q;
    mem_size_e                 size_q;
    logic                      uext_q;
    logic [XLEN-1:0]           vaddr_q, wdata_q;
    logic [BYTES_PER_WORD-1:0] mask_q;
    logic                      misalign_q;

    logic [XLEN-1:0]           vaddr;
    logic [BYTES_PER_WORD-1:0] mask;
    logic                      misalign;
    logic [XLEN-1:0]           merged, load_data;
    logic                      ack_set, is_load;

    lsu_addr_gen u_addr_gen (
        .base_i(base_i), .imm_i(imm_i), .size_i(size_i),
        .vaddr_o(vaddr), .mask_o(mask), .misalign_o(misalign)
    );

    assign is_load   = (op_q == OP_LOAD);
    assign exc_code_o = is_load ? EXC_LAM : EXC_SAM;
    assign exc_set_o   = (state_q == ST_ACCESS) && misalign_q;
    assign exc_vaddr_o = vaddr_q;

    assign ram_rd_en_o  = (state_q == ST_ACCESS) && is_load && !misalign_q;
    assign ram_rd_idx_o = vaddr_q[MEM_IDX_W+OFFSET_W-1:OFFSET_W];
    assign sb_push_o = (state_q == ST_ACCESS) && !is_load && !misalign_q && !sb_full_i;
    assign sb_addr_o  = vaddr_q;
    assign sb_mask_o  = mask_q;
    assign sb_data_o  = wdata_q;
    assign fwd_addr_o = vaddr_q;

    // buffered lanes win over the RAM word
    always_comb begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            merged[8*b +: 8] = fwd_mask_i[b] ? fwd_data_i[8*b +: 8] : ram_data_i[8*b +: 8];
        end
    end

    lsu_load_align u_load_align (
        .word_i(merged), .offset_i(vaddr_q[OFFSET_W-1:0]), .size_i(size_q),
        .uext_i(uext_q), .data_o(load_data)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (req_i) state_d = ST_ADDR;
            ST_ADDR:    state_d = ST_ACCESS;
            ST_ACCESS: begin
                if (is_load || misalign_q) begin
                    state_d = ST_ACK;
                end else if (!sb_full_i) begin
                    state_d = ST_RELEASE;
                end
            end
            ST_ACK:     state_d = ST_RELEASE;
            ST_RELEASE: if (!req_i) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    // stores finish one state early
    assign ack_set = (state_q == ST_ACK) || sb_push_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            ack_o   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ack_set) begin
                ack_o <= 1'b1;
            end else if (state_q == ST_RELEASE && !req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_ADDR) begin
            op_q       <= op_i;
            size_q     <= size_i;
            uext_q     <= uext_i;
            vaddr_q    <= vaddr;
            mask_q     <= mask;
            misalign_q <= misalign;
            wdata_q    <= wdata_i;
        end
        if (ack_set) begin
            rdata_o <= (is_load && !misalign_q) ? load_data : '0;
            exc_o   <= misalign_q ? exc_code_o : EXC_NONE;
        end
    end

    // req_i is checked at the edge that raised ack_o
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack_o) |-> $past(req_i)
    );

endmodule

// ==== lsu_data_ram.sv ====
`timescale 1ns/1ns

module lsu_data_ram import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rd_en_i,
    input  logic [MEM_IDX_W-1:0]      rd_idx_i,
    input  logic                      wr_en_i,
    input  logic [MEM_IDX_W-1:0]      wr_idx_i,
    input  logic [BYTES_PER_WORD-1:0] wr_mask_i,
    input  logic [XLEN-1:0]           wr_data_i,
    output logic [XLEN-1:0]           rd_data_o
);

    logic [XLEN-1:0] mem [MEM_WORDS];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (wr_mask_i[b]) begin
                    mem[wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_idx_i];
        end
    end

endmodule

// ==== lsu_exc_record.sv ====
`timescale 1ns/1ns

module lsu_exc_record import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            set_i,
    input  exc_code_e       code_i,
    input  logic [XLEN-1:0] vaddr_i,
    input  logic            clear_i,
    output logic            valid_o,
    output exc_code_e       code_o,
    output logic [XLEN-1:0] vaddr_o
);

    logic capture;

    // a clear in the same cycle makes room for the new fault
    assign capture = set_i && (!valid_o || clear_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
            code_o  <= EXC_NONE;
            vaddr_o <= '0;
        end else if (capture) begin
            valid_o <= 1'b1;
            code_o  <= code_i;
            vaddr_o <= vaddr_i;
        end else if (clear_i) begin
            valid_o <= 1'b0;
        end
    end

    a_set_has_code: assert property (
        @(posedge clk) disable iff (rst) set_i |-> code_i != EXC_NONE
    );

endmodule

// ==== lsu_load_align.sv ====
`timescale 1ns/1ns

module lsu_load_align import lsu_pkg::*; (
    input  logic [XLEN-1:0]     word_i,
    input  logic [OFFSET_W-1:0] offset_i,
    input  mem_size_e           size_i,
    input  logic                uext_i,
    output logic [XLEN-1:0]     data_o
);

    logic [XLEN-1:0] shifted;
    logic            sign;

    // addressed byte moved down to lane 0
    assign shifted = word_i >> (8 * offset_i);

    always_comb begin
        sign = 1'b0;
        case (size_i)
            SIZE_BYTE: begin
                sign   = ~uext_i & shifted[7];
                data_o = {{(XLEN-8){sign}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                sign   = ~uext_i & shifted[15];
                data_o = {{(XLEN-16){sign}}, shifted[15:0]};
            end
            default: begin
                data_o = shifted;
            end
        endcase
    end

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

    localparam int XLEN           = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int OFFSET_W       = 2;

    // 1 KiB data memory, word organised
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = 8;

    localparam int SB_DEPTH = 4;
    localparam int SB_CNT_W = 3;

    typedef enum logic [0:0] {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_LAM  = 2'd1,
        EXC_SAM  = 2'd2
    } exc_code_e;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_ADDR    = 3'd1,
        ST_ACCESS  = 3'd2,
        ST_ACK     = 3'd3,
        ST_RELEASE = 3'd4
    } lsu_state_e;

endpackage

// ==== lsu_stim.txt ====
# cmd size uext base imm wdata exp_rdata exp_exc, all hex (size 0 byte 1 half 2 word)
# X line: base is the expected fault address, exp_rdata the expected valid bit
S 2 0 00000100 00000000 a1b2c3d4 00000000 0
L 2 0 00000100 00000000 00000000 a1b2c3d4 0
L 0 0 00000100 00000001 00000000 ffffffc3 0
L 0 1 00000100 00000001 00000000 000000c3 0
L 0 0 000000f0 00000013 00000000 ffffffa1 0
L 0 1 00000110 fffffff3 00000000 000000a1 0
L 1 0 00000100 00000002 00000000 ffffa1b2 0
L 1 1 00000102 00000000 00000000 0000a1b2 0
L 1 0 00000100 00000000 00000000 ffffc3d4 0
L 0 0 00000100 00000000 00000000 ffffffd4 0
S 0 0 00000105 00000000 abcdef7f 00000000 0
L 0 0 00000105 00000000 00000000 0000007f 0
L 2 0 00000104 00000000 00000000 00007f00 0
S 2 0 00000200 00000000 11223344 00000000 0
S 0 0 00000200 00000001 000000aa 00000000 0
S 1 0 00000202 00000000 0000bbcc 00000000 0
S 0 0 00000203 00000000 123456dd 00000000 0
S 2 0 00000204 00000000 cafef00d 00000000 0
S 1 0 00000200 00000000 0000eeff 00000000 0
S 0 0 00000202 00000000 00000099 00000000 0
L 2 0 00000200 00000000 00000000 dd99eeff 0
L 2 0 00000204 00000000 00000000 cafef00d 0
L 1 1 00000202 00000000 00000000 0000dd99 0
L 0 0 00000201 00000000 00000000 ffffffee 0
L 1 0 00000201 00000000 00000000 00000000 1
L 2 0 00000202 00000000 00000000 00000000 1
S 2 0 00000205 00000000 ffffffff 00000000 2
S 1 0 00000203 00000000 0000ffff 00000000 2
L 2 0 00000204 00000000 00000000 cafef00d 0
L 2 0 00000200 00000000 00000000 dd99eeff 0
X 0 0 00000201 00000000 00000000 00000001 1
X 0 0 00000000 00000000 00000000 00000000 0
S 2 0 00000300 00000002 12345678 00000000 2
X 0 0 00000302 00000000 00000000 00000001 2
S 2 0 00000400 00000008 5a5aa5a5 00000000 0
L 2 0 00000008 00000000 00000000 5a5aa5a5 0
L 2 0 00001000 00000008 00000000 5a5aa5a5 0
L 0 1 fffffc09 00000000 00000000 000000a5 0
L 2 0 00000380 00000000 00000000 00000000 0

// ==== lsu_store_buffer.sv ====
`timescale 1ns/1ns

module lsu_store_buffer import lsu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push_i,
    input  logic [XLEN-1:0]           push_addr_i,
    input  logic [BYTES_PER_WORD-1:0] push_mask_i,
    input  logic [XLEN-1:0]           push_data_i,
    input  logic [XLEN-1:0]           fwd_addr_i,
    input  logic                      ram_busy_i,
    output logic                      full_o,
    output logic [BYTES_PER_WORD-1:0] fwd_mask_o,
    output logic [XLEN-1:0]           fwd_data_o,
    output logic                      wr_en_o,
    output logic [MEM_IDX_W-1:0]      wr_idx_o,
    output logic [BYTES_PER_WORD-1:0] wr_mask_o,
    output logic [XLEN-1:0]           wr_data_o
);

    logic [MEM_IDX_W-1:0]      sb_idx_q  [SB_DEPTH];
    logic [BYTES_PER_WORD-1:0] sb_mask_q [SB_DEPTH];
    logic [XLEN-1:0]           sb_data_q [SB_DEPTH];

    logic [SB_CNT_W-2:0] head_q;
    logic [SB_CNT_W-2:0] tail_q;
    logic [SB_CNT_W-1:0] count_q;

    logic [MEM_IDX_W-1:0] push_idx;
    logic [MEM_IDX_W-1:0] fwd_idx;

    // only bits 9:0 reach the RAM, so higher addresses alias
    assign push_idx = push_addr_i[MEM_IDX_W+OFFSET_W-1:OFFSET_W];
    assign fwd_idx  = fwd_addr_i[MEM_IDX_W+OFFSET_W-1:OFFSET_W];

    assign full_o = (count_q == SB_CNT_W'(SB_DEPTH));

    // drain oldest whenever the RAM port is free
    assign wr_en_o   = (count_q != '0) && !ram_busy_i;
    assign wr_idx_o  = sb_idx_q[head_q];
    assign wr_mask_o = sb_mask_q[head_q];
    assign wr_data_o = sb_data_q[head_q];

    always_ff @(posedge clk) begin
        if (push_i) begin
            sb_idx_q[tail_q]  <= push_idx;
            sb_mask_q[tail_q] <= push_mask_i;
            sb_data_q[tail_q] <= push_data_i << (8 * push_addr_i[OFFSET_W-1:0]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (wr_en_o) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + SB_CNT_W'(push_i) - SB_CNT_W'(wr_en_o);
        end
    end

    // newest entry first, each lane taken once
    always_comb begin
        logic [SB_CNT_W-2:0] slot;
        fwd_mask_o = '0;
        fwd_data_o = '0;
        for (int k = SB_DEPTH - 1; k >= 0; k--) begin
            slot = head_q + (SB_CNT_W-1)'(k);
            if (k < count_q && sb_idx_q[slot] == fwd_idx) begin
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    if (sb_mask_q[slot][b] && !fwd_mask_o[b]) begin
                        fwd_mask_o[b]          = 1'b1;
                        fwd_data_o[8*b +: 8] = sb_data_q[slot][8*b +: 8];
                    end
                end
            end
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push_i |-> !full_o
    );

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_i,
    input  mem_op_e         op_i,
    input  mem_size_e       size_i,
    input  logic            uext_i,
    input  logic [XLEN-1:0] base_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic            exc_clear_i,
    output logic            ack_o,
    output logic [XLEN-1:0] rdata_o,
    output exc_code_e       exc_o,
    output logic            exc_valid_o,
    output exc_code_e       exc_code_o,
    output logic [XLEN-1:0] exc_vaddr_o
);

    logic                      ram_rd_en, sb_push, sb_full, exc_set, wr_en;
    logic [MEM_IDX_W-1:0]      ram_rd_idx, wr_idx;
    logic [XLEN-1:0]           ram_data, sb_addr, sb_data, fwd_addr, fwd_data, wr_data;
    logic [XLEN-1:0]           exc_vaddr;
    logic [BYTES_PER_WORD-1:0] sb_mask, fwd_mask, wr_mask;
    exc_code_e                 exc_code;

    lsu_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req_i(req_i), .op_i(op_i), .size_i(size_i),
        .uext_i(uext_i), .base_i(base_i), .imm_i(imm_i), .wdata_i(wdata_i),
        .sb_full_i(sb_full), .fwd_mask_i(fwd_mask), .fwd_data_i(fwd_data),
        .ram_data_i(ram_data), .ack_o(ack_o), .rdata_o(rdata_o), .exc_o(exc_o),
        .ram_rd_en_o(ram_rd_en), .ram_rd_idx_o(ram_rd_idx), .sb_push_o(sb_push),
        .sb_addr_o(sb_addr), .sb_mask_o(sb_mask), .sb_data_o(sb_data),
        .fwd_addr_o(fwd_addr), .exc_set_o(exc_set), .exc_code_o(exc_code),
        .exc_vaddr_o(exc_vaddr)
    );

    lsu_store_buffer u_store_buffer (
        .clk(clk), .rst(rst), .push_i(sb_push), .push_addr_i(sb_addr),
        .push_mask_i(sb_mask), .push_data_i(sb_data), .fwd_addr_i(fwd_addr),
        .ram_busy_i(ram_rd_en), .full_o(sb_full), .fwd_mask_o(fwd_mask),
        .fwd_data_o(fwd_data), .wr_en_o(wr_en), .wr_idx_o(wr_idx),
        .wr_mask_o(wr_mask), .wr_data_o(wr_data)
    );

    lsu_data_ram u_data_ram (
        .clk(clk), .rd_en_i(ram_rd_en), .rd_idx_i(ram_rd_idx), .wr_en_i(wr_en),
        .wr_idx_i(wr_idx), .wr_mask_i(wr_mask), .wr_data_i(wr_data),
        .rd_data_o(ram_data)
    );

    lsu_exc_record u_exc_record (
        .clk(clk), .rst(rst), .set_i(exc_set), .code_i(exc_code),
        .vaddr_i(exc_vaddr), .clear_i(exc_clear_i), .valid_o(exc_valid_o),
        .code_o(exc_code_o), .vaddr_o(exc_vaddr_o)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu \
        -f verilog.f -o sim_lsu \
    && ./obj_dir/sim_lsu \
    || { echo "build or simulation returned an error status"; exit 1; }

// ==== tb_lsu.sv ====
`timescale 1ns/1ns

module tb_lsu import lsu_pkg::*; ();

    localparam int ACK_TIMEOUT = 50;

    logic            clk;
    logic            rst;
    logic            req_i;
    mem_op_e         op_i;
    mem_size_e       size_i;
    logic            uext_i;
    logic [XLEN-1:0] base_i;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] wdata_i;
    logic            exc_clear_i;
    logic            ack_o;
    logic [XLEN-1:0] rdata_o;
    exc_code_e       exc_o;
    logic            exc_valid_o;
    exc_code_e       exc_code_o;
    logic [XLEN-1:0] exc_vaddr_o;

    logic [15:0] lfsr_q;

    lsu_top dut0 (
        .clk(clk), .rst(rst), .req_i(req_i), .op_i(op_i), .size_i(size_i),
        .uext_i(uext_i), .base_i(base_i), .imm_i(imm_i), .wdata_i(wdata_i),
        .exc_clear_i(exc_clear_i), .ack_o(ack_o), .rdata_o(rdata_o), .exc_o(exc_o),
        .exc_valid_o(exc_valid_o), .exc_code_o(exc_code_o), .exc_vaddr_o(exc_vaddr_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_exc(input string name, input exc_code_e got, input exc_code_e exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_record(input logic valid, input exc_code_e code,
                                input logic [XLEN-1:0] vaddr, input logic exp_valid,
                                input exc_code_e exp_code, input logic [XLEN-1:0] exp_vaddr);
        if (valid !== exp_valid) begin
            stop_with_failure($sformatf("ERR exc_valid_o got %h expected %h",
                                        valid, exp_valid));
        end
        // code and address only mean something while the record is full
        if (exp_valid) begin
            check_exc("exc_code_o", code, exp_code);
            check_data("exc_vaddr_o", vaddr, exp_vaddr);
        end
    endtask

    // 0 to 3 idle cycles, two LFSR bits
    task automatic idle_gap;
        int n;
        n = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            n = 2 * n + int'(lfsr_q[0]);
        end
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack_o !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                stop_with_failure($sformatf("ack_o did not %s within %0d cycles",
                                            level ? "rise" : "fall", ACK_TIMEOUT));
            end
        end
    endtask

    task automatic run_access(input mem_op_e op, input mem_size_e size, input logic uext,
                              input logic [XLEN-1:0] base, input logic [XLEN-1:0] imm,
                              input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] exp_rdata,
                              input exc_code_e exp_exc);
        idle_gap();
        @(posedge clk);
        #1;
        op_i    = op;
        size_i  = size;
        uext_i  = uext;
        base_i  = base;
        imm_i   = imm;
        wdata_i = wdata;
        req_i   = 1'b1;
        wait_ack(1'b1);
        check_exc("exc_o", exc_o, exp_exc);
        if (op == OP_LOAD && exp_exc == EXC_NONE) begin
            check_data("rdata_o", rdata_o, exp_rdata);
        end
        req_i = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic check_and_clear(input logic exp_valid, input exc_code_e exp_code,
                                   input logic [XLEN-1:0] exp_vaddr);
        @(posedge clk);
        #1;
        check_record(exc_valid_o, exc_code_o, exc_vaddr_o, exp_valid, exp_code, exp_vaddr);
        exc_clear_i = 1'b1;
        @(posedge clk);
        #1;
        exc_clear_i = 1'b0;
        check_record(exc_valid_o, exc_code_o, exc_vaddr_o, 1'b0, EXC_NONE, '0);
    endtask

    initial begin
        int              fd;
        int              n_fields;
        int              n_ops;
        string           line;
        logic [7:0]      cmd;
        logic [1:0]      size_v;
        logic            uext_v;
        logic [XLEN-1:0] base_v, imm_v, wdata_v, exp_v;
        logic [1:0]      exc_v;

        rst         = 1'b1;
        req_i       = 1'b0;
        op_i        = OP_LOAD;
        size_i      = SIZE_WORD;
        uext_i      = 1'b0;
        base_i      = '0;
        imm_i       = '0;
        wdata_i     = '0;
        exc_clear_i = 1'b0;
        lfsr_q      = 16'd50105;
        n_ops       = 0;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("lsu_stim.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open lsu_stim.txt");
        end

        while (!$feof(fd)) begin
            line = "";
            n_fields = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%c %h %h %h %h %h %h %h", cmd, size_v, uext_v,
                               base_v, imm_v, wdata_v, exp_v, exc_v);
            if (n_fields != 8) begin
                stop_with_failure($sformatf("malformed stimulus line: %s", line));
            end
            case (cmd)
                "L": run_access(OP_LOAD, mem_size_e'(size_v), uext_v, base_v, imm_v,
                                wdata_v, exp_v, exc_code_e'(exc_v));
                "S": run_access(OP_STORE, mem_size_e'(size_v), uext_v, base_v, imm_v,
                                wdata_v, exp_v, exc_code_e'(exc_v));
                // X reuses base for the fault address and rdata for valid
                "X": check_and_clear(exp_v[0], exc_code_e'(exc_v), base_v);
                default: stop_with_failure("unknown command in stimulus file");
            endcase
            n_ops++;
        end
        $fclose(fd);

        if (n_ops == 0) begin
            stop_with_failure("no operations were read from the stimulus file");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
lsu_pkg.sv
lsu_addr_gen.sv
lsu_data_ram.sv
lsu_store_buffer.sv
lsu_load_align.sv
lsu_exc_record.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu.sv
